// File: hw/rv32i_pkg.sv
`default_nettype none

package rv32i_pkg;

    localparam int XLEN      = 32;
    localparam int REG_IDX_W = 5;

    // major opcodes kept by this core
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_REG    = 7'b0110011;

    // arithmetic funct3
    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_SLL = 3'b001;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;

    typedef struct packed {
        logic [6:0]           funct7;
        logic [REG_IDX_W-1:0] rs2;
        logic [REG_IDX_W-1:0] rs1;
        logic [2:0]           funct3;
        logic [REG_IDX_W-1:0] rd;
        logic [6:0]           opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0]          imm;
        logic [REG_IDX_W-1:0] rs1;
        logic [2:0]           funct3;
        logic [REG_IDX_W-1:0] rd;
        logic [6:0]           opcode;
    } i_type_t;

    typedef struct packed {
        logic [6:0]           imm_hi;
        logic [REG_IDX_W-1:0] rs2;
        logic [REG_IDX_W-1:0] rs1;
        logic [2:0]           funct3;
        logic [4:0]           imm_lo;
        logic [6:0]           opcode;
    } s_type_t;

    // branch offset bits are scattered over the word
    typedef struct packed {
        logic                 imm_12;
        logic [5:0]           imm_10_5;
        logic [REG_IDX_W-1:0] rs2;
        logic [REG_IDX_W-1:0] rs1;
        logic [2:0]           funct3;
        logic [3:0]           imm_4_1;
        logic                 imm_11;
        logic [6:0]           opcode;
    } b_type_t;

    typedef struct packed {
        logic [19:0]          imm;
        logic [REG_IDX_W-1:0] rd;
        logic [6:0]           opcode;
    } u_type_t;

    typedef union packed {
        r_type_t r;
        i_type_t i;
        s_type_t s;
        b_type_t b;
        u_type_t u;
    } instr_word_u;

endpackage

`default_nettype wire

// File: hw/issue_pkg.sv
`default_nettype none

package issue_pkg;

    localparam int ALU_OP_W = 3;

    // alu codes reuse the funct3 encoding
    localparam logic [ALU_OP_W-1:0] ALU_ADD = 3'b000;
    localparam logic [ALU_OP_W-1:0] ALU_SLL = 3'b001;
    localparam logic [ALU_OP_W-1:0] ALU_XOR = 3'b100;
    localparam logic [ALU_OP_W-1:0] ALU_OR  = 3'b110;
    localparam logic [ALU_OP_W-1:0] ALU_AND = 3'b111;
    // free slot, shift-right is not issued
    localparam logic [ALU_OP_W-1:0] ALU_SUB = 3'b101;

    localparam int UNIT_W = 2;

    // destination unit of a decoded instruction
    localparam logic [UNIT_W-1:0] UNIT_NONE = 2'd0;
    localparam logic [UNIT_W-1:0] UNIT_ALU  = 2'd1;
    localparam logic [UNIT_W-1:0] UNIT_CMP  = 2'd2;
    localparam logic [UNIT_W-1:0] UNIT_LSB  = 2'd3;

endpackage

`default_nettype wire

// File: hw/instr_field_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module instr_field_decoder
    import rv32i_pkg::*;
    import issue_pkg::*;
(
    input  instr_word_u          instr_i,
    output logic [UNIT_W-1:0]    unit_o,
    output logic                 writes_rd_o,
    output logic [REG_IDX_W-1:0] rs1_o,
    output logic [REG_IDX_W-1:0] rs2_o,
    output logic [REG_IDX_W-1:0] rd_o,
    output logic [ALU_OP_W-1:0]  alu_op_o,
    output logic [2:0]           funct3_o,
    output logic                 use_imm_o,
    output logic                 use_pc_o,
    output logic                 is_store_o,
    output logic [XLEN-1:0]      imm_o,
    output logic                 supported_o
);

    logic [XLEN-1:0] i_imm;
    logic [XLEN-1:0] s_imm;
    logic [XLEN-1:0] b_imm;
    logic [XLEN-1:0] u_imm;
    logic            arith_ok;

    assign rs1_o    = instr_i.r.rs1;
    assign rs2_o    = instr_i.r.rs2;
    assign rd_o     = instr_i.r.rd;
    assign funct3_o = instr_i.r.funct3;

    // sign-extended immediates, one per format
    assign i_imm = {{20{instr_i.i.imm[11]}}, instr_i.i.imm};
    assign s_imm = {{20{instr_i.s.imm_hi[6]}}, instr_i.s.imm_hi, instr_i.s.imm_lo};
    assign b_imm = {{19{instr_i.b.imm_12}}, instr_i.b.imm_12, instr_i.b.imm_11,
                    instr_i.b.imm_10_5, instr_i.b.imm_4_1, 1'b0};
    assign u_imm = {instr_i.u.imm, 12'h000};

    // slt, sltu and shift-right fall outside this set
    assign arith_ok = funct3_o inside {F3_ADD, F3_SLL, F3_XOR, F3_OR, F3_AND};

    always_comb begin
        unit_o      = UNIT_NONE;
        writes_rd_o = 1'b0;
        alu_op_o    = ALU_ADD;
        use_imm_o   = 1'b0;
        use_pc_o    = 1'b0;
        is_store_o  = 1'b0;
        imm_o       = '0;
        supported_o = 1'b0;
        case (instr_i.r.opcode)
            OPC_AUIPC: begin
                unit_o      = UNIT_ALU;
                writes_rd_o = 1'b1;
                use_imm_o   = 1'b1;
                use_pc_o    = 1'b1;
                imm_o       = u_imm;
                supported_o = 1'b1;
            end
            OPC_BRANCH: begin
                unit_o      = UNIT_CMP;
                imm_o       = b_imm;
                // funct3 010 and 011 are not branches
                supported_o = (funct3_o[2:1] != 2'b01);
            end
            OPC_LOAD: begin
                unit_o      = UNIT_LSB;
                writes_rd_o = 1'b1;
                imm_o       = i_imm;
                supported_o = funct3_o inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101};
            end
            OPC_STORE: begin
                unit_o      = UNIT_LSB;
                is_store_o  = 1'b1;
                imm_o       = s_imm;
                supported_o = funct3_o inside {3'b000, 3'b001, 3'b010};
            end
            OPC_IMM: begin
                unit_o      = UNIT_ALU;
                writes_rd_o = 1'b1;
                use_imm_o   = 1'b1;
                imm_o       = i_imm;
                alu_op_o    = funct3_o;
                supported_o = arith_ok;
            end
            OPC_REG: begin
                unit_o      = UNIT_ALU;
                writes_rd_o = 1'b1;
                // funct7 bit 5 turns add into sub
                if (funct3_o == F3_ADD && instr_i.r.funct7[5]) begin
                    alu_op_o = ALU_SUB;
                end else begin
                    alu_op_o = funct3_o;
                end
                supported_o = arith_ok;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: hw/operand_bypass.sv
`timescale 1ns/1ps
`default_nettype none

module operand_bypass
    import rv32i_pkg::*;
#(
    parameter int TAG_W = 3
) (
    input  logic [XLEN-1:0]                 rf_value_i,
    input  logic [TAG_W-1:0]                rf_tag_i,
    input  logic [2**TAG_W-1:0]             rob_ready_i,
    input  logic [2**TAG_W-1:0][XLEN-1:0]   rob_value_i,
    output logic [XLEN-1:0]                 value_o,
    output logic [TAG_W-1:0]                tag_o,
    output logic                            ready_o
);

    logic rob_hit;

    // tag 0 never names a producer
    assign rob_hit = (rf_tag_i != '0) && rob_ready_i[rf_tag_i];

    // producer already finished, take its value from the rob
    assign value_o = rob_hit ? rob_value_i[rf_tag_i] : rf_value_i;
    assign tag_o   = rob_hit ? '0 : rf_tag_i;
    assign ready_o = (tag_o == '0);

endmodule

`default_nettype wire

// File: hw/issue_control.sv
`timescale 1ns/1ps
`default_nettype none

module issue_control
    import rv32i_pkg::*;
    import issue_pkg::*;
#(
    parameter int TAG_W = 3
) (
    input  logic                 instr_valid_i,
    input  logic [UNIT_W-1:0]    unit_i,
    input  logic                 writes_rd_i,
    input  logic                 supported_i,
    input  logic [REG_IDX_W-1:0] rd_i,
    input  logic [TAG_W-1:0]     rob_free_tag_i,
    input  logic                 rob_full_i,
    input  logic                 alu_full_i,
    input  logic                 cmp_full_i,
    input  logic                 lsb_full_i,
    output logic                 iqueue_read_o,
    output logic                 fire_alu_o,
    output logic                 fire_cmp_o,
    output logic                 fire_lsb_o,
    output logic                 rename_o
);

    logic discard;
    logic unit_full;
    logic rob_room;
    logic issue;

    // dropped encodings and writes to x0 are popped without effect
    assign discard = !supported_i || (writes_rd_i && rd_i == '0);

    always_comb begin
        case (unit_i)
            UNIT_ALU: unit_full = alu_full_i;
            UNIT_CMP: unit_full = cmp_full_i;
            UNIT_LSB: unit_full = lsb_full_i;
            default:  unit_full = 1'b1;
        endcase
    end

    // tag 0 is reserved, so a zero free tag also means no room
    assign rob_room = !rob_full_i && (rob_free_tag_i != '0);

    assign issue = instr_valid_i && !discard && rob_room && !unit_full;

    // pop on issue or discard, hold the queue on a stall
    assign iqueue_read_o = issue || (instr_valid_i && discard);

    assign fire_alu_o = issue && (unit_i == UNIT_ALU);
    assign fire_cmp_o = issue && (unit_i == UNIT_CMP);
    assign fire_lsb_o = issue && (unit_i == UNIT_LSB);

    // stores and branches leave the rename table alone
    assign rename_o = issue && writes_rd_i;

endmodule

`default_nettype wire

// File: hw/dispatch_regs.sv
`timescale 1ns/1ps
`default_nettype none

module dispatch_regs
    import rv32i_pkg::*;
    import issue_pkg::*;
#(
    parameter int TAG_W = 3
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 fire_alu_i,
    input  logic                 fire_cmp_i,
    input  logic                 fire_lsb_i,
    input  logic                 rename_i,
    input  logic [REG_IDX_W-1:0] rd_i,
    input  logic [ALU_OP_W-1:0]  alu_op_i,
    input  logic [2:0]           funct3_i,
    input  logic                 use_imm_i,
    input  logic                 use_pc_i,
    input  logic                 is_store_i,
    input  logic [XLEN-1:0]      imm_i,
    input  logic [XLEN-1:0]      a_value_i,
    input  logic [TAG_W-1:0]     a_tag_i,
    input  logic                 a_ready_i,
    input  logic [XLEN-1:0]      b_value_i,
    input  logic [TAG_W-1:0]     b_tag_i,
    input  logic                 b_ready_i,
    input  logic [XLEN-1:0]      pc_i,
    input  logic [TAG_W-1:0]     rob_free_tag_i,
    output logic                 alu_valid_o,
    output logic [ALU_OP_W-1:0]  alu_op_o,
    output logic [XLEN-1:0]      alu_a_value_o,
    output logic                 alu_a_ready_o,
    output logic [TAG_W-1:0]     alu_a_tag_o,
    output logic [XLEN-1:0]      alu_b_value_o,
    output logic                 alu_b_ready_o,
    output logic [TAG_W-1:0]     alu_b_tag_o,
    output logic [TAG_W-1:0]     alu_rob_tag_o,
    output logic                 cmp_valid_o,
    output logic [2:0]           cmp_op_o,
    output logic [XLEN-1:0]      cmp_a_value_o,
    output logic                 cmp_a_ready_o,
    output logic [TAG_W-1:0]     cmp_a_tag_o,
    output logic [XLEN-1:0]      cmp_b_value_o,
    output logic                 cmp_b_ready_o,
    output logic [TAG_W-1:0]     cmp_b_tag_o,
    output logic [XLEN-1:0]      cmp_pc_o,
    output logic [XLEN-1:0]      cmp_offset_o,
    output logic [TAG_W-1:0]     cmp_rob_tag_o,
    output logic                 lsb_valid_o,
    output logic                 lsb_store_o,
    output logic [2:0]           lsb_funct_o,
    output logic [XLEN-1:0]      lsb_base_value_o,
    output logic                 lsb_base_ready_o,
    output logic [TAG_W-1:0]     lsb_base_tag_o,
    output logic [XLEN-1:0]      lsb_data_value_o,
    output logic                 lsb_data_ready_o,
    output logic [TAG_W-1:0]     lsb_data_tag_o,
    output logic [XLEN-1:0]      lsb_offset_o,
    output logic [TAG_W-1:0]     lsb_rob_tag_o,
    output logic                 rob_write_o,
    output logic [XLEN-1:0]      rob_pc_o,
    output logic [REG_IDX_W-1:0] rob_rd_o,
    output logic                 tag_load_o,
    output logic [REG_IDX_W-1:0] tag_rd_o,
    output logic [TAG_W-1:0]     tag_o
);

    logic fire_any;

    assign fire_any = fire_alu_i | fire_cmp_i | fire_lsb_i;

    // alu station
    always_ff @(posedge clk) begin
        if (rst) begin
            alu_valid_o <= 1'b0;
            alu_op_o <= '0;
            {alu_a_value_o, alu_a_ready_o, alu_a_tag_o} <= '0;
            {alu_b_value_o, alu_b_ready_o, alu_b_tag_o} <= '0;
            alu_rob_tag_o <= '0;
        end else begin
            alu_valid_o <= fire_alu_i;
            if (fire_alu_i) begin
                alu_op_o <= alu_op_i;
                // auipc adds the pc, constants go out ready with tag 0
                alu_a_value_o <= use_pc_i ? pc_i : a_value_i;
                alu_a_ready_o <= use_pc_i | a_ready_i;
                alu_a_tag_o <= use_pc_i ? '0 : a_tag_i;
                alu_b_value_o <= use_imm_i ? imm_i : b_value_i;
                alu_b_ready_o <= use_imm_i | b_ready_i;
                alu_b_tag_o <= use_imm_i ? '0 : b_tag_i;
                alu_rob_tag_o <= rob_free_tag_i;
            end
        end
    end

    // compare station, branches only
    always_ff @(posedge clk) begin
        if (rst) begin
            cmp_valid_o <= 1'b0;
            cmp_op_o <= '0;
            {cmp_a_value_o, cmp_a_ready_o, cmp_a_tag_o} <= '0;
            {cmp_b_value_o, cmp_b_ready_o, cmp_b_tag_o} <= '0;
            {cmp_pc_o, cmp_offset_o, cmp_rob_tag_o} <= '0;
        end else begin
            cmp_valid_o <= fire_cmp_i;
            if (fire_cmp_i) begin
                cmp_op_o <= funct3_i;
                {cmp_a_value_o, cmp_a_ready_o, cmp_a_tag_o} <= {a_value_i, a_ready_i, a_tag_i};
                {cmp_b_value_o, cmp_b_ready_o, cmp_b_tag_o} <= {b_value_i, b_ready_i, b_tag_i};
                cmp_pc_o <= pc_i;
                cmp_offset_o <= imm_i;
                cmp_rob_tag_o <= rob_free_tag_i;
            end
        end
    end

    // load-store buffer
    always_ff @(posedge clk) begin
        if (rst) begin
            {lsb_valid_o, lsb_store_o, lsb_funct_o} <= '0;
            {lsb_base_value_o, lsb_base_ready_o, lsb_base_tag_o} <= '0;
            {lsb_data_value_o, lsb_data_ready_o, lsb_data_tag_o} <= '0;
            {lsb_offset_o, lsb_rob_tag_o} <= '0;
        end else begin
            lsb_valid_o <= fire_lsb_i;
            if (fire_lsb_i) begin
                lsb_store_o <= is_store_i;
                lsb_funct_o <= funct3_i;
                lsb_base_value_o <= a_value_i;
                lsb_base_ready_o <= a_ready_i;
                lsb_base_tag_o <= a_tag_i;
                // a load has no data operand
                lsb_data_value_o <= is_store_i ? b_value_i : '0;
                lsb_data_ready_o <= !is_store_i | b_ready_i;
                lsb_data_tag_o <= is_store_i ? b_tag_i : '0;
                lsb_offset_o <= imm_i;
                lsb_rob_tag_o <= rob_free_tag_i;
            end
        end
    end

    // rob entry and rename of rd
    always_ff @(posedge clk) begin
        if (rst) begin
            {rob_write_o, rob_pc_o, rob_rd_o} <= '0;
            {tag_load_o, tag_rd_o, tag_o} <= '0;
        end else begin
            rob_write_o <= fire_any;
            if (fire_any) begin
                rob_pc_o <= pc_i;
                rob_rd_o <= rename_i ? rd_i : '0;
            end
            tag_load_o <= rename_i;
            if (rename_i) begin
                tag_rd_o <= rd_i;
                tag_o <= rob_free_tag_i;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/issue_top.sv
`timescale 1ns/1ps
`default_nettype none

module issue_top
    import rv32i_pkg::*;
    import issue_pkg::*;
#(
    parameter int TAG_W = 3
) (
    input  logic                          clk,
    input  logic                          rst,
    // instruction queue
    input  logic                          instr_valid_i,
    input  instr_word_u                   instr_i,
    input  logic [XLEN-1:0]               pc_i,
    output logic                          iqueue_read_o,
    // register file
    output logic [REG_IDX_W-1:0]          rs1_o, rs2_o,
    input  logic [XLEN-1:0]               rf_vj_i, rf_vk_i,
    input  logic [TAG_W-1:0]              rf_qj_i, rf_qk_i,
    output logic                          tag_load_o,
    output logic [REG_IDX_W-1:0]          tag_rd_o,
    output logic [TAG_W-1:0]              tag_o,
    // reorder buffer
    input  logic [TAG_W-1:0]              rob_free_tag_i,
    input  logic                          rob_full_i,
    input  logic [2**TAG_W-1:0]           rob_ready_i,
    input  logic [2**TAG_W-1:0][XLEN-1:0] rob_value_i,
    output logic                          rob_write_o,
    output logic [XLEN-1:0]               rob_pc_o,
    output logic [REG_IDX_W-1:0]          rob_rd_o,
    // stations
    input  logic                          alu_full_i, cmp_full_i, lsb_full_i,
    output logic                          alu_valid_o, cmp_valid_o, lsb_valid_o,
    output logic [ALU_OP_W-1:0]           alu_op_o,
    output logic [2:0]                    cmp_op_o, lsb_funct_o,
    output logic                          lsb_store_o,
    output logic [XLEN-1:0]               alu_a_value_o, alu_b_value_o,
    output logic [XLEN-1:0]               cmp_a_value_o, cmp_b_value_o,
    output logic [XLEN-1:0]               lsb_base_value_o, lsb_data_value_o,
    output logic                          alu_a_ready_o, alu_b_ready_o,
    output logic                          cmp_a_ready_o, cmp_b_ready_o,
    output logic                          lsb_base_ready_o, lsb_data_ready_o,
    output logic [TAG_W-1:0]              alu_a_tag_o, alu_b_tag_o, alu_rob_tag_o,
    output logic [TAG_W-1:0]              cmp_a_tag_o, cmp_b_tag_o, cmp_rob_tag_o,
    output logic [TAG_W-1:0]              lsb_base_tag_o, lsb_data_tag_o, lsb_rob_tag_o,
    output logic [XLEN-1:0]               cmp_pc_o, cmp_offset_o, lsb_offset_o
);

    logic [UNIT_W-1:0]    unit;
    logic                 writes_rd;
    logic [REG_IDX_W-1:0] rd;
    logic [ALU_OP_W-1:0]  alu_op;
    logic [2:0]           funct3;
    logic                 use_imm;
    logic                 use_pc;
    logic                 is_store;
    logic [XLEN-1:0]      imm;
    logic                 supported;
    logic [XLEN-1:0]      a_value, b_value;
    logic [TAG_W-1:0]     a_tag, b_tag;
    logic                 a_ready, b_ready;
    logic                 fire_alu, fire_cmp, fire_lsb;
    logic                 rename;

    instr_field_decoder u_decoder (
        .instr_i     (instr_i),
        .unit_o      (unit),
        .writes_rd_o (writes_rd),
        .rs1_o       (rs1_o),
        .rs2_o       (rs2_o),
        .rd_o        (rd),
        .alu_op_o    (alu_op),
        .funct3_o    (funct3),
        .use_imm_o   (use_imm),
        .use_pc_o    (use_pc),
        .is_store_o  (is_store),
        .imm_o       (imm),
        .supported_o (supported)
    );

    // one bypass per source operand
    operand_bypass #(.TAG_W(TAG_W)) u_bypass_a (
        .rf_value_i  (rf_vj_i),
        .rf_tag_i    (rf_qj_i),
        .rob_ready_i (rob_ready_i),
        .rob_value_i (rob_value_i),
        .value_o     (a_value),
        .tag_o       (a_tag),
        .ready_o     (a_ready)
    );

    operand_bypass #(.TAG_W(TAG_W)) u_bypass_b (
        .rf_value_i  (rf_vk_i),
        .rf_tag_i    (rf_qk_i),
        .rob_ready_i (rob_ready_i),
        .rob_value_i (rob_value_i),
        .value_o     (b_value),
        .tag_o       (b_tag),
        .ready_o     (b_ready)
    );

    issue_control #(.TAG_W(TAG_W)) u_control (
        .instr_valid_i  (instr_valid_i),
        .unit_i         (unit),
        .writes_rd_i    (writes_rd),
        .supported_i    (supported),
        .rd_i           (rd),
        .rob_free_tag_i (rob_free_tag_i),
        .rob_full_i     (rob_full_i),
        .alu_full_i     (alu_full_i),
        .cmp_full_i     (cmp_full_i),
        .lsb_full_i     (lsb_full_i),
        .iqueue_read_o  (iqueue_read_o),
        .fire_alu_o     (fire_alu),
        .fire_cmp_o     (fire_cmp),
        .fire_lsb_o     (fire_lsb),
        .rename_o       (rename)
    );

    // outputs, clk, rst, pc_i and rob_free_tag_i connect by name
    dispatch_regs #(.TAG_W(TAG_W)) u_dispatch (
        .fire_alu_i (fire_alu),
        .fire_cmp_i (fire_cmp),
        .fire_lsb_i (fire_lsb),
        .rename_i   (rename),
        .rd_i       (rd),
        .alu_op_i   (alu_op),
        .funct3_i   (funct3),
        .use_imm_i  (use_imm),
        .use_pc_i   (use_pc),
        .is_store_i (is_store),
        .imm_i      (imm),
        .a_value_i  (a_value),
        .a_tag_i    (a_tag),
        .a_ready_i  (a_ready),
        .b_value_i  (b_value),
        .b_tag_i    (b_tag),
        .b_ready_i  (b_ready),
        .*
    );

endmodule

`default_nettype wire

// File: bench/issue_tb.sv
`timescale 1ns/1ps
`default_nettype none

module issue_tb
    import rv32i_pkg::*;
    import issue_pkg::*;
();

    localparam int TAG_W      = 3;
    localparam int N_CASES    = 23;
    localparam int N_FIELDS   = 17;
    localparam int CLK_PERIOD = 40;
    localparam int TIMEOUT_NS = (N_CASES * 4 + 4 + 4) * CLK_PERIOD;
    localparam logic [31:0] SEED = 32'h81d3aa99;

    logic        clk;
    logic        rst;
    logic [31:0] case_mem [0:N_CASES*N_FIELDS-1];
    int          case_no;
    int unsigned seed_ret;

    // dut inputs
    logic                          instr_valid_i;
    instr_word_u                   instr_i;
    logic [XLEN-1:0]               pc_i;
    logic [XLEN-1:0]               rf_vj_i, rf_vk_i;
    logic [TAG_W-1:0]              rf_qj_i, rf_qk_i;
    logic [TAG_W-1:0]              rob_free_tag_i;
    logic                          rob_full_i;
    logic [2**TAG_W-1:0]           rob_ready_i;
    logic [2**TAG_W-1:0][XLEN-1:0] rob_value_i;
    logic                          alu_full_i, cmp_full_i, lsb_full_i;

    // dut outputs
    logic                 iqueue_read_o;
    logic [REG_IDX_W-1:0] rs1_o, rs2_o, tag_rd_o, rob_rd_o;
    logic                 tag_load_o, rob_write_o;
    logic [TAG_W-1:0]     tag_o;
    logic [XLEN-1:0]      rob_pc_o;
    logic                 alu_valid_o, cmp_valid_o, lsb_valid_o, lsb_store_o;
    logic [ALU_OP_W-1:0]  alu_op_o;
    logic [2:0]           cmp_op_o, lsb_funct_o;
    logic [XLEN-1:0]      alu_a_value_o, alu_b_value_o, cmp_a_value_o, cmp_b_value_o;
    logic [XLEN-1:0]      lsb_base_value_o, lsb_data_value_o;
    logic [XLEN-1:0]      cmp_pc_o, cmp_offset_o, lsb_offset_o;
    logic                 alu_a_ready_o, alu_b_ready_o, cmp_a_ready_o, cmp_b_ready_o;
    logic                 lsb_base_ready_o, lsb_data_ready_o;
    logic [TAG_W-1:0]     alu_a_tag_o, alu_b_tag_o, alu_rob_tag_o;
    logic [TAG_W-1:0]     cmp_a_tag_o, cmp_b_tag_o, cmp_rob_tag_o;
    logic [TAG_W-1:0]     lsb_base_tag_o, lsb_data_tag_o, lsb_rob_tag_o;

    issue_top #(.TAG_W(TAG_W)) UUT (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic compare_value(input logic [31:0] actual, input logic [31:0] expected,
                                 input string what);
        if (actual !== expected) begin
            $display("Mismatch at %0t ns, case %0d: %s, got %h, expected %h",
                     $time, case_no, what, actual, expected);
            $display("TESTS FAILED");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    // case file packs ready into bit 4 and the tag below it
    function automatic logic [31:0] ready_tag(input logic ready, input logic [TAG_W-1:0] tag);
        ready_tag = '0;
        ready_tag[4] = ready;
        ready_tag[TAG_W-1:0] = tag;
    endfunction

    task automatic expect_idle(input string when);
        compare_value(alu_valid_o, 0, {"alu valid ", when});
        compare_value(cmp_valid_o, 0, {"cmp valid ", when});
        compare_value(lsb_valid_o, 0, {"lsb valid ", when});
        compare_value(rob_write_o, 0, {"rob write ", when});
        compare_value(tag_load_o, 0, {"tag load ", when});
    endtask

    task automatic fill_rob_values();
        for (int i = 0; i < 2**TAG_W; i++) begin
            rob_value_i[i] = $urandom;
        end
    endtask

    task automatic run_case(input int n);
        int          base;
        logic [31:0] ctrl;
        logic [31:0] flags;
        logic [1:0]  unit;
        logic [31:0] exp_rd;
        logic [31:0] op;
        logic [31:0] a_value;
        logic [31:0] a_rt;
        logic [31:0] b_value;
        logic [31:0] b_rt;
        logic [31:0] rob_tag;
        base  = n * N_FIELDS;
        ctrl  = case_mem[base + 9];
        flags = case_mem[base + 10];
        unit  = flags[9:8];
        op = '0;
        a_value = '0;
        a_rt = '0;
        b_value = '0;
        b_rt = '0;
        rob_tag = '0;

        instr_i        = case_mem[base];
        pc_i           = case_mem[base + 1];
        rf_vj_i        = case_mem[base + 2];
        rf_qj_i        = case_mem[base + 3][TAG_W-1:0];
        rf_vk_i        = case_mem[base + 4];
        rf_qk_i        = case_mem[base + 5][TAG_W-1:0];
        rob_ready_i    = case_mem[base + 6][2**TAG_W-1:0];
        fill_rob_values();
        rob_value_i[case_mem[base + 7][TAG_W-1:0]] = case_mem[base + 8];
        rob_free_tag_i = ctrl[16 +: TAG_W];
        rob_full_i     = ctrl[12];
        alu_full_i     = ctrl[8];
        cmp_full_i     = ctrl[4];
        lsb_full_i     = ctrl[0];
        instr_valid_i  = 1'b1;
        exp_rd = flags[4] ? 32'(instr_i.r.rd) : 32'h0;

        // combinational side in the same cycle
        #1;
        compare_value(iqueue_read_o, flags[12], "queue pop strobe");
        compare_value(rs1_o, instr_i.r.rs1, "rs1 index");
        compare_value(rs2_o, instr_i.r.rs2, "rs2 index");

        // registered side after one edge
        @(posedge clk);
        #1;
        compare_value(alu_valid_o, unit == UNIT_ALU, "alu valid pulse");
        compare_value(cmp_valid_o, unit == UNIT_CMP, "cmp valid pulse");
        compare_value(lsb_valid_o, unit == UNIT_LSB, "lsb valid pulse");
        compare_value(rob_write_o, unit != UNIT_NONE, "rob write pulse");
        compare_value(tag_load_o, flags[4], "tag load pulse");
        if (flags[4]) begin
            compare_value(tag_rd_o, instr_i.r.rd, "renamed rd");
            compare_value(tag_o, rob_free_tag_i, "rename tag");
        end
        case (unit)
            UNIT_ALU: begin
                op      = alu_op_o;
                a_value = alu_a_value_o;
                a_rt    = ready_tag(alu_a_ready_o, alu_a_tag_o);
                b_value = alu_b_value_o;
                b_rt    = ready_tag(alu_b_ready_o, alu_b_tag_o);
                rob_tag = alu_rob_tag_o;
            end
            UNIT_CMP: begin
                op      = cmp_op_o;
                a_value = cmp_a_value_o;
                a_rt    = ready_tag(cmp_a_ready_o, cmp_a_tag_o);
                b_value = cmp_b_value_o;
                b_rt    = ready_tag(cmp_b_ready_o, cmp_b_tag_o);
                rob_tag = cmp_rob_tag_o;
                compare_value(cmp_pc_o, pc_i, "branch pc");
                compare_value(cmp_offset_o, case_mem[base + 16], "branch offset");
            end
            UNIT_LSB: begin
                op      = lsb_funct_o;
                a_value = lsb_base_value_o;
                a_rt    = ready_tag(lsb_base_ready_o, lsb_base_tag_o);
                b_value = lsb_data_value_o;
                b_rt    = ready_tag(lsb_data_ready_o, lsb_data_tag_o);
                rob_tag = lsb_rob_tag_o;
                compare_value(lsb_store_o, flags[0], "store flag");
                compare_value(lsb_offset_o, case_mem[base + 16], "memory offset");
            end
            default: ;
        endcase
        if (unit != UNIT_NONE) begin
            compare_value(rob_pc_o, pc_i, "rob pc");
            compare_value(rob_rd_o, exp_rd, "rob rd");
            compare_value(op, case_mem[base + 11], "operation code");
            compare_value(a_value, case_mem[base + 12], "first operand value");
            compare_value(a_rt, case_mem[base + 13], "first operand ready and tag");
            compare_value(b_value, case_mem[base + 14], "second operand value");
            compare_value(b_rt, case_mem[base + 15], "second operand ready and tag");
            compare_value(rob_tag, rob_free_tag_i, "station rob tag");
        end
        #1;
        instr_valid_i = 1'b0;

        // pulses last one cycle only
        @(posedge clk);
        #1;
        expect_idle("one cycle after the pulse");
        #1;
    endtask

    initial begin
        seed_ret = $urandom(SEED);
        clk = 1'b0;
        rst = 1'b1;
        case_no = -1;
        // an add x3, x1, x2 that would issue if reset let it
        instr_valid_i = 1'b1;
        instr_i = 32'h002081b3;
        pc_i = 32'h00000100;
        rf_vj_i = 32'h00000001;
        rf_vk_i = 32'h00000002;
        rf_qj_i = '0;
        rf_qk_i = '0;
        rob_free_tag_i = 3'd3;
        rob_full_i = 1'b0;
        rob_ready_i = '0;
        rob_value_i = '0;
        alu_full_i = 1'b0;
        cmp_full_i = 1'b0;
        lsb_full_i = 1'b0;

        $readmemh("bench/issue_cases.txt", case_mem);
        if (^case_mem[N_CASES * N_FIELDS - 1] === 1'bx) begin
            $display("case file is missing or holds fewer than %0d cases", N_CASES);
            $display("TESTS FAILED");
            $fatal(1, "cannot load the cases");
        end

        repeat (4) @(posedge clk);
        #1;
        expect_idle("during reset");
        compare_value(alu_a_value_o, 0, "alu payload during reset");
        compare_value(cmp_offset_o, 0, "cmp payload during reset");
        compare_value(lsb_offset_o, 0, "lsb payload during reset");
        compare_value(rob_pc_o, 0, "rob payload during reset");
        compare_value(tag_o, 0, "rename tag during reset");
        #1;
        rst = 1'b0;

        for (int n = 0; n < N_CASES; n++) begin
            case_no = n;
            run_case(n);
        end
        $display("TESTS PASSED");
        $finish;
    end

    // watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("timeout, the cases did not finish within %0d ns", TIMEOUT_NS);
        $display("TESTS FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

// File: bench/issue_cases.txt
// instr pc vj qj vk qk rob_ready rob_idx rob_val ctrl(free_tag rob alu cmp lsb full)
// expected: flags(pop unit rename store) op a_val a_rt b_val b_rt offset, rt = ready<<4 | tag
002081b3 1000 00000011 0 00000022 0 00 0 0 30011 1110 0 00000011 10 00000022 10 0
407302b3 1004 00000100 0 00000001 0 00 0 0 30000 1110 5 00000100 10 00000001 10 0
00a49433 1008 0000000f 0 00000004 0 00 0 0 50000 1110 1 0000000f 10 00000004 10 0
00d645b3 100c a5a5a5a5 0 ffff0000 0 00 0 0 30000 1110 4 a5a5a5a5 10 ffff0000 10 0
0107e733 1010 12340000 0 00005678 0 00 0 0 70000 1110 6 12340000 10 00005678 10 0
013978b3 1014 f0f0f0f0 0 0ff00ff0 0 00 0 0 10000 1110 7 f0f0f0f0 10 0ff00ff0 10 0
ffb10093 1018 00000040 0 deadbeef 2 00 0 0 20000 1110 0 00000040 10 fffffffb 10 0
7ff2c213 101c 00000800 0 00000000 0 00 0 0 30000 1110 4 00000800 10 000007ff 10 0
12345517 2000 11111111 4 00000000 0 00 0 0 60000 1110 0 00002000 10 12345000 10 0
002081b3 2004 00000000 5 00000077 6 20 5 cafef00d 30000 1110 0 cafef00d 10 00000077 06 0
fe208ce3 3000 00000005 0 00000005 0 00 0 0 40100 1200 0 00000005 10 00000005 10 fffffff8
0062f0e3 3004 00000000 2 00000009 0 00 0 0 20000 1200 7 00000000 02 00000009 10 00000800
ffc42383 4000 00008000 0 12345678 2 00 0 0 30110 1310 2 00008000 10 00000000 10 fffffffc
fe21a623 4004 00009000 0 0badc0de 0 00 0 0 50000 1301 2 00009000 10 0badc0de 10 ffffffec
024282a3 4008 00000000 1 00000000 3 08 3 000000ab 70000 1301 0 00000000 01 000000ab 10 00000025
002081b3 5000 00000011 0 00000022 0 00 0 0 30100 0000 0 0 0 0 0 0
fe21a623 5004 00009000 0 0badc0de 0 00 0 0 31000 0000 0 0 0 0 0 0
ffc42383 5008 00008000 0 00000000 0 00 0 0 00000 0000 0 0 0 0 0 0
fe208ce3 500c 00000005 0 00000005 0 00 0 0 30010 0000 0 0 0 0 0 0
00208033 6000 00000011 0 00000022 0 00 0 0 30100 1000 0 0 0 0 0 0
000012b7 6004 0 0 0 0 00 0 0 30000 1000 0 0 0 0 0 0
0020a1b3 6008 0 0 0 0 00 0 0 30000 1000 0 0 0 0 0 0
0012d213 600c 0 0 0 0 00 0 0 30000 1000 0 0 0 0 0 0

// File: issue_top.f
hw/rv32i_pkg.sv
hw/issue_pkg.sv
hw/instr_field_decoder.sv
hw/operand_bypass.sv
hw/issue_control.sv
hw/dispatch_regs.sv
hw/issue_top.sv
bench/issue_tb.sv
